// ==== verilog/fpslice_pkg.sv ====
package fpslice_pkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------
  localparam int unsigned WIDTH         = 32;  // Slice width
  localparam int unsigned NUM_LANES     = 2;   // FP16 lanes in one word
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned NUM_FORMATS   = 2;
  localparam int unsigned TAG_WIDTH     = 8;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } operation_e;

  // Selects the variant of an operation
  typedef enum logic [2:0] {
    RNE = 3'b000,  // SGNJ.J or MIN
    RTZ = 3'b001,  // SGNJ.JN or MAX
    RDN = 3'b010,  // SGNJ.JX
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  // One slice word that reads as a single FP32 or as two FP16 values
  typedef union packed {
    fp32_t           f32;
    fp16_t [1:0]     f16;  // Index 0 is the low half
  } lane_word_u;

  // Canonical quiet NaNs and the NaN-box pattern
  localparam logic [15:0] QNAN16   = 16'h7E00;
  localparam logic [31:0] QNAN32   = 32'h7FC0_0000;
  localparam logic [15:0] FP16_BOX = 16'hFFFF;

endpackage

// ==== verilog/fpslice_pipe_if.sv ====
`timescale 1ns/100ps

interface fpslice_pipe_if import fpslice_pkg::*; ();

  logic [NUM_PIPE_REGS-1:0] reg_en;           // Load enable per stage
  logic [NUM_LANES-1:0]     out_lane_active;  // Lanes used by the output op
  logic [NUM_LANES-1:0]     out_lane_mask;    // SIMD status mask at output
  fp_format_e               out_fmt;

  // Aux pipeline drives everything
  modport ctrl (
    output reg_en,
    output out_lane_active,
    output out_lane_mask,
    output out_fmt
  );

  modport lane (
    input reg_en
  );

  // Output side lane information for result assembly
  modport pack (
    input out_lane_active,
    input out_lane_mask,
    input out_fmt
  );

endinterface

// ==== verilog/fpslice_aux_pipe.sv ====
`timescale 1ns/100ps

module fpslice_aux_pipe import fpslice_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  input  fp_format_e           fmt_i,
  input  logic [NUM_LANES-1:0] lane_active_i,
  input  logic [NUM_LANES-1:0] lane_mask_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 busy_o,
  fpslice_pipe_if.ctrl         pipe
);

  logic [NUM_PIPE_REGS-1:0] valid_q;
  logic [NUM_PIPE_REGS-1:0] valid_in;     // Valid offered to each stage
  logic [NUM_PIPE_REGS:0]   ready_chain;  // Stage i may load
  logic [NUM_PIPE_REGS-1:0] reg_en;

  logic [NUM_PIPE_REGS-1:0][TAG_WIDTH-1:0] tag_q;
  fp_format_e [NUM_PIPE_REGS-1:0]          fmt_q;
  logic [NUM_PIPE_REGS-1:0][NUM_LANES-1:0] active_q;
  logic [NUM_PIPE_REGS-1:0][NUM_LANES-1:0] mask_q;

  // --------------------------------------------------------------------------
  // Handshake chain
  // --------------------------------------------------------------------------
  always_comb begin : handshake
    ready_chain[NUM_PIPE_REGS] = out_ready_i;
    for (int i = NUM_PIPE_REGS - 1; i >= 0; i--) begin
      ready_chain[i] = ready_chain[i+1] | ~valid_q[i];  // Empty or moving on
    end
    valid_in[0] = in_valid_i;
    for (int i = 1; i < NUM_PIPE_REGS; i++) begin
      valid_in[i] = valid_q[i-1];
    end
    reg_en = valid_in & ready_chain[NUM_PIPE_REGS-1:0];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_regs
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;  // Drop everything in flight
    end else begin
      for (int i = 0; i < NUM_PIPE_REGS; i++) begin
        if (ready_chain[i]) valid_q[i] <= valid_in[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Aux registers
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    logic [TAG_WIDTH-1:0] tag_d;
    fp_format_e           fmt_d;
    logic [NUM_LANES-1:0] active_d;
    logic [NUM_LANES-1:0] mask_d;

    if (i == 0) begin : gen_first
      assign tag_d    = tag_i;
      assign fmt_d    = fmt_i;
      assign active_d = lane_active_i;
      assign mask_d   = lane_mask_i;
    end else begin : gen_next
      assign tag_d    = tag_q[i-1];
      assign fmt_d    = fmt_q[i-1];
      assign active_d = active_q[i-1];
      assign mask_d   = mask_q[i-1];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : aux_regs
      if (!rst_n_i) begin
        tag_q[i]    <= '0;
        fmt_q[i]    <= FP32;
        active_q[i] <= '0;
        mask_q[i]   <= '0;
      end else if (flush_i) begin
        tag_q[i]    <= '0;
        fmt_q[i]    <= FP32;
        active_q[i] <= '0;
        mask_q[i]   <= '0;
      end else if (reg_en[i]) begin
        tag_q[i]    <= tag_d;
        fmt_q[i]    <= fmt_d;
        active_q[i] <= active_d;
        mask_q[i]   <= mask_d;
      end
    end
  end

  // Output side
  assign in_ready_o           = ready_chain[0];
  assign out_valid_o          = valid_q[NUM_PIPE_REGS-1];
  assign tag_o                = tag_q[NUM_PIPE_REGS-1];
  assign busy_o               = |valid_q;
  assign pipe.reg_en          = reg_en;
  assign pipe.out_fmt         = fmt_q[NUM_PIPE_REGS-1];
  assign pipe.out_lane_active = active_q[NUM_PIPE_REGS-1];
  assign pipe.out_lane_mask   = mask_q[NUM_PIPE_REGS-1];

endmodule

// ==== verilog/fpslice_noncomp_lane.sv ====
`timescale 1ns/100ps

module fpslice_noncomp_lane import fpslice_pkg::*; #(
  parameter bit SUPPORT_FP32 = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [WIDTH-1:0] op_a_i,
  input  logic [WIDTH-1:0] op_b_i,
  input  logic             boxed_a_i,
  input  logic             boxed_b_i,
  input  fp_format_e       fmt_i,
  input  operation_e       op_i,
  input  roundmode_e       rnd_mode_i,
  output logic [WIDTH-1:0] result_o,
  output status_t          status_o,
  fpslice_pipe_if.lane     pipe
);

  logic        is_fp32;
  fp32_t       a32, b32;
  fp16_t       a16, b16;
  logic        sign_a, sign_b;
  logic [30:0] mag_a, mag_b;  // FP16 magnitudes are zero-extended
  logic        nan_a, nan_b;
  logic        snan_a, snan_b;
  logic        a_lt_b;
  logic        pick_a;
  logic        canonical;
  logic        res_sign;
  logic [30:0] res_mag;
  logic [WIDTH-1:0] op_result;
  status_t     op_status;

  assign is_fp32 = SUPPORT_FP32 && (fmt_i == FP32);
  assign a32     = op_a_i;
  assign b32     = op_b_i;
  assign a16     = boxed_a_i ? op_a_i[15:0] : QNAN16;  // Unboxed reads as qNaN
  assign b16     = boxed_b_i ? op_b_i[15:0] : QNAN16;

  // --------------------------------------------------------------------------
  // Operand classification
  // --------------------------------------------------------------------------
  always_comb begin : classify
    if (is_fp32) begin
      sign_a = a32.sign;
      sign_b = b32.sign;
      mag_a  = {a32.exponent, a32.mantissa};
      mag_b  = {b32.exponent, b32.mantissa};
      nan_a  = (&a32.exponent) & (|a32.mantissa);
      nan_b  = (&b32.exponent) & (|b32.mantissa);
      snan_a = nan_a & ~a32.mantissa[22];  // Quiet bit clear
      snan_b = nan_b & ~b32.mantissa[22];
    end else begin
      sign_a = a16.sign;
      sign_b = b16.sign;
      mag_a  = {16'b0, a16.exponent, a16.mantissa};
      mag_b  = {16'b0, b16.exponent, b16.mantissa};
      nan_a  = (&a16.exponent) & (|a16.mantissa);
      nan_b  = (&b16.exponent) & (|b16.mantissa);
      snan_a = nan_a & ~a16.mantissa[9];
      snan_b = nan_b & ~b16.mantissa[9];
    end
  end

  // Sign-magnitude compare puts -0 below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // --------------------------------------------------------------------------
  // Sign injection and min/max
  // --------------------------------------------------------------------------
  always_comb begin : operation
    pick_a    = 1'b1;
    canonical = 1'b0;
    op_status = '0;
    res_sign  = sign_a;
    res_mag   = mag_a;
    if (op_i == SGNJ) begin
      case (rnd_mode_i)
        RTZ:     res_sign = ~sign_b;          // JN
        RDN:     res_sign = sign_a ^ sign_b;  // JX
        default: res_sign = sign_b;           // J
      endcase
    end else begin
      op_status.NV = snan_a | snan_b;
      if (nan_a && nan_b) begin
        canonical = 1'b1;
      end else if (nan_b) begin
        pick_a = 1'b1;  // Return the number
      end else if (nan_a) begin
        pick_a = 1'b0;
      end else begin
        pick_a = (rnd_mode_i == RTZ) ? ~a_lt_b : a_lt_b;  // MAX : MIN
      end
      if (!pick_a) begin
        res_sign = sign_b;
        res_mag  = mag_b;
      end
    end
  end

  always_comb begin : assemble
    if (is_fp32) begin
      op_result = canonical ? QNAN32 : {res_sign, res_mag};
    end else begin
      op_result = {FP16_BOX, canonical ? QNAN16 : {res_sign, res_mag[14:0]}};
    end
  end

  // --------------------------------------------------------------------------
  // Result pipeline enabled in step with the aux stages
  // --------------------------------------------------------------------------
  logic [NUM_PIPE_REGS-1:0][WIDTH-1:0] res_q;
  status_t [NUM_PIPE_REGS-1:0]         status_q;

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    logic [WIDTH-1:0] res_d;
    status_t          status_d;

    if (i == 0) begin : gen_first
      assign res_d    = op_result;
      assign status_d = op_status;
    end else begin : gen_next
      assign res_d    = res_q[i-1];
      assign status_d = status_q[i-1];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : stage_regs
      if (!rst_n_i) begin
        res_q[i]    <= '0;
        status_q[i] <= '0;
      end else if (pipe.reg_en[i]) begin
        res_q[i]    <= res_d;
        status_q[i] <= status_d;
      end
    end
  end

  assign result_o = res_q[NUM_PIPE_REGS-1];
  assign status_o = status_q[NUM_PIPE_REGS-1];

endmodule

// ==== verilog/fpslice_result_pack.sv ====
`timescale 1ns/100ps

module fpslice_result_pack import fpslice_pkg::*; (
  input  logic [NUM_LANES-1:0][WIDTH-1:0] lane_result_i,
  input  status_t [NUM_LANES-1:0]         lane_status_i,
  output logic [WIDTH-1:0]                result_o,
  output status_t                         status_o,
  fpslice_pipe_if.pack                    pipe
);

  lane_word_u packed_word;

  // --------------------------------------------------------------------------
  // Result assembly
  // --------------------------------------------------------------------------
  always_comb begin : pack_result
    packed_word = lane_result_i[0];  // FP32 comes straight from lane 0
    if (pipe.out_fmt == FP16) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        // Unused halves are NaN-boxed
        packed_word.f16[l] = pipe.out_lane_active[l] ? lane_result_i[l][15:0] : FP16_BOX;
      end
    end
  end

  assign result_o = packed_word;

  // Only active and unmasked lanes feed the status
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (pipe.out_lane_active[l] && pipe.out_lane_mask[l]) begin
        status_o = status_o | lane_status_i[l];
      end
    end
  end

endmodule

// ==== verilog/fpslice_top.sv ====
`timescale 1ns/100ps

module fpslice_top import fpslice_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [1:0][WIDTH-1:0]         operands_i,
  input  logic [NUM_FORMATS-1:0][1:0]   is_boxed_i,
  input  roundmode_e                    rnd_mode_i,
  input  operation_e                    op_i,
  input  fp_format_e                    fmt_i,
  input  logic                          vectorial_op_i,
  input  logic [TAG_WIDTH-1:0]          tag_i,
  input  logic [NUM_LANES-1:0]          simd_mask_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  output logic [WIDTH-1:0]              result_o,
  output status_t                       status_o,
  output logic [TAG_WIDTH-1:0]          tag_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  lane_word_u                      opa_word, opb_word;
  logic                            vec_fp16;  // Vectorial FP32 runs as scalar
  logic [NUM_LANES-1:0]            in_lane_active;
  logic [NUM_LANES-1:0][WIDTH-1:0] lane_op_a, lane_op_b;
  logic [NUM_LANES-1:0]            lane_boxed_a, lane_boxed_b;
  logic [NUM_LANES-1:0][WIDTH-1:0] lane_result;
  status_t [NUM_LANES-1:0]         lane_status;

  fpslice_pipe_if pipe_if ();

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  assign opa_word = operands_i[0];
  assign opb_word = operands_i[1];
  assign vec_fp16 = vectorial_op_i & (fmt_i == FP16);

  always_comb begin : slice_operands
    for (int l = 0; l < NUM_LANES; l++) begin
      if (l == 0) begin
        lane_op_a[l]      = opa_word;
        lane_op_b[l]      = opb_word;
        lane_boxed_a[l]   = vec_fp16 | is_boxed_i[FP16][0];
        lane_boxed_b[l]   = vec_fp16 | is_boxed_i[FP16][1];
        in_lane_active[l] = 1'b1;
      end else begin
        // Upper FP16 halves move down into the lane
        lane_op_a[l]      = {FP16_BOX, opa_word.f16[l]};
        lane_op_b[l]      = {FP16_BOX, opb_word.f16[l]};
        lane_boxed_a[l]   = 1'b1;
        lane_boxed_b[l]   = 1'b1;
        in_lane_active[l] = vec_fp16;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Aux pipeline, lanes and packer
  // --------------------------------------------------------------------------
  fpslice_aux_pipe u_aux_pipe (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .flush_i       (flush_i),
    .tag_i         (tag_i),
    .fmt_i         (fmt_i),
    .lane_active_i (in_lane_active),
    .lane_mask_i   (simd_mask_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .tag_o         (tag_o),
    .busy_o        (busy_o),
    .pipe          (pipe_if)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    fpslice_noncomp_lane #(
      .SUPPORT_FP32 (l == 0)  // Only lane 0 sees FP32
    ) u_lane (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .op_a_i     (lane_op_a[l]),
      .op_b_i     (lane_op_b[l]),
      .boxed_a_i  (lane_boxed_a[l]),
      .boxed_b_i  (lane_boxed_b[l]),
      .fmt_i      (fmt_i),
      .op_i       (op_i),
      .rnd_mode_i (rnd_mode_i),
      .result_o   (lane_result[l]),
      .status_o   (lane_status[l]),
      .pipe       (pipe_if)
    );
  end

  fpslice_result_pack u_result_pack (
    .lane_result_i (lane_result),
    .lane_status_i (lane_status),
    .result_o      (result_o),
    .status_o      (status_o),
    .pipe          (pipe_if)
  );

endmodule

// ==== tests/fpslice_clk_gen.sv ====
`timescale 1ns/100ps

module fpslice_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  always begin : toggle
    clk_o = 1'b0;
    #(PERIOD_NS / 2.0);
    clk_o = 1'b1;  // Rising edge mid period
    #(PERIOD_NS / 2.0);
  end

endmodule

// ==== tests/fpslice_properties.sv ====
`timescale 1ns/100ps

module fpslice_properties import fpslice_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 flush_i,
  input logic                 in_ready_o,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic                 busy_o,
  input logic [WIDTH-1:0]     result_o,
  input status_t              status_o,
  input logic [TAG_WIDTH-1:0] tag_o
);

  int unsigned failures = 0;

  // --------------------------------------------------------------------------
  // Output side holds while the sink stalls
  // --------------------------------------------------------------------------
  property stall_holds;
    @(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_o && !out_ready_i && !flush_i) |=>
        (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));
  endproperty

  property reset_clears;
    @(posedge clk_i) $rose(rst_n_i) |-> (!out_valid_o && !busy_o);
  endproperty

  // An empty pipeline always takes new work
  property idle_ready;
    @(posedge clk_i) disable iff (!rst_n_i) !busy_o |-> in_ready_o;
  endproperty

  stall_chk: assert property (stall_holds) else begin
    failures++;
    $error("Output changed or dropped while stalled");
  end

  reset_chk: assert property (reset_clears) else begin
    failures++;
    $error("Output valid or busy set right after reset");
  end

  ready_chk: assert property (idle_ready) else begin
    failures++;
    $error("Input not ready while the pipeline is idle");
  end

endmodule

bind fpslice_top fpslice_properties props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .result_o    (result_o),
  .status_o    (status_o),
  .tag_o       (tag_o)
);

// ==== tests/fpslice_tb.sv ====
`timescale 1ns/100ps

module fpslice_tb import fpslice_pkg::*; ();

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic [WIDTH-1:0]     result;
    status_t              status;
    logic                 chk_lat;  // Latency must be exactly two cycles
    logic [31:0]          cyc;      // Cycle of the accepting edge
  } exp_t;

  logic                          clk;
  logic                          rst_n;
  logic [1:0][WIDTH-1:0]         operands;
  logic [NUM_FORMATS-1:0][1:0]   is_boxed;
  roundmode_e                    rnd_mode;
  operation_e                    op;
  fp_format_e                    fmt;
  logic                          vectorial_op;
  logic [TAG_WIDTH-1:0]          tag;
  logic [NUM_LANES-1:0]          simd_mask;
  logic                          in_valid;
  logic                          in_ready;
  logic                          flush;
  logic [WIDTH-1:0]              result;
  status_t                       status;
  logic [TAG_WIDTH-1:0]          tag_out;
  logic                          out_valid;
  logic                          out_ready;
  logic                          busy;

  exp_t        exp_q[$];
  logic [31:0] rng_state = 32'd22;
  int unsigned cycle = 0;
  int unsigned sent = 0;
  int unsigned checked = 0;
  int unsigned errors = 0;
  int unsigned test_sent0 = 0;
  int unsigned test_err0 = 0;
  bit          rand_ready = 1'b0;
  // Ops per test are 24, 33, 40, 200 and 3
  int unsigned timeout_cycles = (24 + 33 + 40 + 200 + 3) * 4 + 200;

  logic [31:0] mm_a [12] = '{32'h3F80_0000, 32'hC000_0000, 32'h8000_0000, 32'h0000_0000,
                             32'h7FC0_0000, 32'hBF80_0000, 32'h7FC0_0000, 32'h7F80_0001,
                             32'h4040_0000, 32'h7F80_0000, 32'h7FA0_0000, 32'hC120_0000};
  logic [31:0] mm_b [12] = '{32'h4000_0000, 32'h3F80_0000, 32'h0000_0000, 32'h8000_0000,
                             32'h3F80_0000, 32'h7FC0_0000, 32'h7FC1_2345, 32'h4040_0000,
                             32'hFF80_0010, 32'hFF80_0000, 32'h7FA0_0000, 32'hC110_0000};
  logic [31:0] sj32_a [4] = '{32'h3F80_0000, 32'hC049_0FDB, 32'h7FC0_0000, 32'h8000_0000};
  logic [31:0] sj32_b [4] = '{32'hBF80_0000, 32'h4049_0FDB, 32'h8000_0000, 32'h8000_0000};
  logic [31:0] sj16_a [4] = '{32'hFFFF_3C00, 32'hFFFF_C248, 32'hFFFF_7E00, 32'hFFFF_FC00};
  logic [31:0] sj16_b [4] = '{32'hFFFF_BC00, 32'hFFFF_4248, 32'hFFFF_8000, 32'hFFFF_0001};

  fpslice_clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk_o(clk));

  fpslice_top dut0 (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .operands_i     (operands),
    .is_boxed_i     (is_boxed),
    .rnd_mode_i     (rnd_mode),
    .op_i           (op),
    .fmt_i          (fmt),
    .vectorial_op_i (vectorial_op),
    .tag_i          (tag),
    .simd_mask_i    (simd_mask),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .flush_i        (flush),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (tag_out),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .busy_o         (busy)
  );

  // --------------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [15:0] rand_half();
    logic [31:0] r;
    r = next_random();
    if (r[31:29] == 3'b000) r[14:10] = 5'h1F;  // Bias toward Inf and NaN
    return r[15:0];
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w[15:0]  = rand_half();
    w[31:16] = rand_half();
    return w;
  endfunction

  function automatic bit is_nan(input logic [31:0] x, input bit is32);
    return is32 ? (x[30:23] == 8'hFF && x[22:0] != 0) : (x[14:10] == 5'h1F && x[9:0] != 0);
  endfunction

  function automatic bit is_snan(input logic [31:0] x, input bit is32);
    return is_nan(x, is32) && !(is32 ? x[22] : x[9]);
  endfunction

  // Unsigned key that sorts like the float with -0 below +0
  function automatic logic [31:0] order_key(input logic [31:0] x, input bit is32);
    logic [31:0] v;
    v = is32 ? x : {x[15:0], 16'h0};
    return v[31] ? ~v : (v | 32'h8000_0000);
  endfunction

  // One lane with FP16 values in the low half and NV in the top bit
  function automatic logic [32:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                           input bit is32, input operation_e o,
                                           input roundmode_e rm);
    logic [31:0] sign_bit;
    logic        sa, sb, s, nv;
    logic [31:0] r;
    sign_bit = is32 ? 32'h8000_0000 : 32'h0000_8000;
    sa = |(a & sign_bit);
    sb = |(b & sign_bit);
    s  = 1'b0;
    nv = 1'b0;
    if (o == SGNJ) begin
      case (rm)
        RTZ:     s = !sb;
        RDN:     s = sa ^ sb;
        default: s = sb;
      endcase
      r = s ? (a | sign_bit) : (a & ~sign_bit);
    end else begin
      nv = is_snan(a, is32) || is_snan(b, is32);
      if (is_nan(a, is32) && is_nan(b, is32)) r = is32 ? QNAN32 : {16'h0, QNAN16};
      else if (is_nan(a, is32)) r = b;
      else if (is_nan(b, is32)) r = a;
      else if ((rm == RTZ) == (order_key(a, is32) > order_key(b, is32))) r = a;
      else r = b;
    end
    return {nv, r};
  endfunction

  function automatic exp_t fpslice_ref(input logic [31:0] a, input logic [31:0] b,
                                       input fp_format_e f, input bit vec,
                                       input operation_e o, input roundmode_e rm,
                                       input logic [1:0] boxed, input logic [1:0] mask);
    exp_t        e;
    logic [32:0] lo, hi;
    logic [15:0] a16, b16;
    e = '0;
    if (f == FP32) begin
      lo          = lane_ref(a, b, 1'b1, o, rm);
      e.result    = lo[31:0];
      e.status.NV = lo[32] & mask[0];
    end else if (!vec) begin
      a16         = boxed[0] ? a[15:0] : QNAN16;
      b16         = boxed[1] ? b[15:0] : QNAN16;
      lo          = lane_ref({16'h0, a16}, {16'h0, b16}, 1'b0, o, rm);
      e.result    = {16'hFFFF, lo[15:0]};
      e.status.NV = lo[32] & mask[0];
    end else begin
      lo          = lane_ref({16'h0, a[15:0]}, {16'h0, b[15:0]}, 1'b0, o, rm);
      hi          = lane_ref({16'h0, a[31:16]}, {16'h0, b[31:16]}, 1'b0, o, rm);
      e.result    = {hi[15:0], lo[15:0]};
      e.status.NV = (lo[32] & mask[0]) | (hi[32] & mask[1]);
    end
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Driving and bookkeeping
  // --------------------------------------------------------------------------
  task automatic send_op(input logic [31:0] a, input logic [31:0] b, input fp_format_e f,
                         input bit vec, input operation_e o, input roundmode_e rm,
                         input logic [1:0] boxed, input logic [1:0] mask,
                         input bit keep, input bit chk_lat);
    exp_t        e;
    bit          accepted;
    logic [31:0] r;
    e            = fpslice_ref(a, b, f, vec, o, rm, boxed, mask);
    e.tag        = tag;
    e.chk_lat    = chk_lat;
    operands     = {b, a};
    is_boxed     = {boxed, 2'b11};
    fmt          = f;
    vectorial_op = vec;
    op           = o;
    rnd_mode     = rm;
    simd_mask    = mask;
    in_valid     = 1'b1;
    accepted     = 1'b0;
    while (!accepted) begin
      if (rand_ready) begin
        r         = next_random();
        out_ready = |r[9:8];  // Ready three times in four
      end
      @(posedge clk);
      accepted = in_ready;
      e.cyc    = cycle;
      #1;
    end
    in_valid = 1'b0;
    if (keep) exp_q.push_back(e);
    tag++;
    sent++;
  endtask

  task automatic wait_drained();
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(input int num, input string name);
    wait_drained();
    $display("Test %0d %s: %0d ops, %0d errors", num, name, sent - test_sent0,
             errors - test_err0);
    test_sent0 = sent;
    test_err0  = errors;
  endtask

  always @(posedge clk) begin : watchdog
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d results pending", cycle, exp_q.size());
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(posedge clk) begin : compare_outputs
    exp_t e;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output with tag %02h at %0t ns, nothing was pending",
                 tag_out, $time);
      end else begin
        e = exp_q.pop_front();
        checked++;
        if (tag_out !== e.tag || result !== e.result || status !== e.status) begin
          errors++;
          $display("Mismatch at %0t ns: tag %02h result %08h status %05b, %s %02h %08h %05b",
                   $time, tag_out, result, status, "expected", e.tag, e.result, e.status);
        end
        if (e.chk_lat && (cycle - e.cyc) != 2) begin
          errors++;
          $display("Mismatch at %0t ns: tag %02h came %0d cycles after acceptance, expected 2",
                   $time, tag_out, cycle - e.cyc);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] r, va, vb;
    roundmode_e  rm;
    logic [1:0]  bx;
    rst_n        = 1'b0;
    operands     = '0;
    is_boxed     = '1;
    rnd_mode     = RNE;
    op           = SGNJ;
    fmt          = FP32;
    vectorial_op = 1'b0;
    tag          = '0;
    simd_mask    = 2'b11;
    in_valid     = 1'b0;
    flush        = 1'b0;
    out_ready    = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    for (int i = 0; i < 12; i++) begin
      send_op(mm_a[i], mm_b[i], FP32, 1'b0, MINMAX, RNE, 2'b11, 2'b11, 1'b1, 1'b1);
      send_op(mm_a[i], mm_b[i], FP32, 1'b0, MINMAX, RTZ, 2'b11, 2'b11, 1'b1, 1'b1);
    end
    end_test(1, "FP32 min/max");

    for (int m = 0; m < 3; m++) begin
      rm = roundmode_e'(m);
      for (int i = 0; i < 4; i++) begin
        send_op(sj32_a[i], sj32_b[i], FP32, 1'b0, SGNJ, rm, 2'b11, 2'b11, 1'b1, 1'b1);
        send_op(sj16_a[i], sj16_b[i], FP16, 1'b0, SGNJ, rm, 2'b11, 2'b11, 1'b1, 1'b1);
      end
      send_op(32'h0000_3C00, 32'hFFFF_BC00, FP16, 1'b0, SGNJ, rm, 2'b10, 2'b11, 1'b1, 1'b1);
      send_op(32'hFFFF_BC00, 32'h1234_3C00, FP16, 1'b0, SGNJ, rm, 2'b01, 2'b11, 1'b1, 1'b1);
    end
    send_op(32'h0000_1234, 32'hFFFF_4000, FP16, 1'b0, MINMAX, RNE, 2'b10, 2'b11, 1'b1, 1'b1);
    send_op(32'hFFFF_C000, 32'h0000_0000, FP16, 1'b0, MINMAX, RTZ, 2'b01, 2'b11, 1'b1, 1'b1);
    send_op(32'h4049_0FDB, 32'hBF80_0000, FP32, 1'b1, SGNJ, RNE, 2'b11, 2'b11, 1'b1, 1'b1);
    end_test(2, "sign injection");

    for (int i = 0; i < 40; i++) begin
      va = rand_word();
      vb = rand_word();
      r  = next_random();
      send_op(va, vb, FP16, 1'b1, MINMAX, r[0] ? RTZ : RNE, 2'b11, r[2:1], 1'b1, 1'b1);
    end
    end_test(3, "vectorial FP16 min/max");

    rand_ready = 1'b1;
    for (int i = 0; i < 200; i++) begin
      va = rand_word();
      vb = rand_word();
      r  = next_random();
      case (r[1:0])
        2'd1:    rm = RTZ;
        2'd2:    rm = RDN;
        default: rm = RNE;
      endcase
      bx = (r[4:2] == 3'b000) ? r[6:5] : 2'b11;  // Mostly boxed
      send_op(va, vb, fp_format_e'(r[7]), r[8], operation_e'(r[9]), rm, bx, r[11:10],
              1'b1, 1'b0);
    end
    end_test(4, "back-pressure");

    // Two ops held back by the sink and then dropped
    out_ready = 1'b0;
    send_op(32'h3F80_0000, 32'h4000_0000, FP32, 1'b0, MINMAX, RNE, 2'b11, 2'b11, 1'b0, 1'b0);
    send_op(32'hFFFF_3C00, 32'hFFFF_BC00, FP16, 1'b0, SGNJ, RTZ, 2'b11, 2'b11, 1'b0, 1'b0);
    flush = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
    if (out_valid !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("Flush at %0t ns left an operation in the pipeline", $time);
    end
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    send_op(32'hC080_0000, 32'h4080_0000, FP32, 1'b0, MINMAX, RTZ, 2'b11, 2'b11, 1'b1, 1'b1);
    end_test(5, "flush");

    $display("Summary: %0d ops sent, %0d results checked, %0d errors, %0d assertion failures",
             sent, checked, errors, dut0.props.failures);
    if (errors == 0 && dut0.props.failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== fpslice.f ====
verilog/fpslice_pkg.sv
verilog/fpslice_pipe_if.sv
verilog/fpslice_aux_pipe.sv
verilog/fpslice_noncomp_lane.sv
verilog/fpslice_result_pack.sv
verilog/fpslice_top.sv
tests/fpslice_clk_gen.sv
tests/fpslice_properties.sv
tests/fpslice_tb.sv
